// File: compile.f
+incdir+testbench
src/ndn_pkg.sv
src/byte_gather.sv
src/spi_rx_deframer.sv
src/fib_route_regs.sv
src/fib_route_match.sv
src/fib_egress.sv
src/fib_table.sv
testbench/tb_fib_table.sv

// File: Bender.yml
package:
  name: fib_table

sources:
  - files:
      - src/ndn_pkg.sv
      - src/byte_gather.sv
      - src/spi_rx_deframer.sv
      - src/fib_route_regs.sv
      - src/fib_route_match.sv
      - src/fib_egress.sv
      - src/fib_table.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_fib_table.sv

// File: testbench/tb_fib_model.svh
`ifndef TB_FIB_MODEL_SVH
`define TB_FIB_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// Mirror of the route registers, written after each configuration strobe
route_table_t model_routes = '0;

// Searched from four components down, so the first hit is the longest and lowest index
function automatic route_result_t model_lookup(input ndn_prefix_t pfx);
    route_result_t res;
    logic          same;
    int            len;
    int            i;
    int            k;
    res = '0;
    for (len = 4; len >= 1; len--) begin
        for (i = 0; i < route_entries; i++) begin
            same = model_routes[i].valid && (model_routes[i].components == 3'(len));
            for (k = 0; k < len; k++) begin
                if (model_routes[i].prefix[63-16*k -: 16] != pfx[63-16*k -: 16]) begin
                    same = 1'b0;
                end
            end
            if (same && !res.hit) begin
                res.hit  = 1'b1;
                res.face = model_routes[i].face;
            end
        end
    end
    return res;
endfunction

// Places the received bytes into the frame fields, first byte on top
function automatic ndn_frame_t model_frame(input byte_q_t b);
    ndn_frame_t f;
    int         i;
    f = '0;
    f.header.metadata = b[0];
    for (i = 0; i < 8; i++) begin
        f.header.prefix[63-8*i -: 8] = b[1+i];
    end
    if (b[0] == meta_data) begin
        for (i = 0; i < content_bytes; i++) begin
            f.content[255-8*i -: 8] = b[9+i];
        end
    end
    return f;
endfunction

task automatic compare_frame(input string name, input ndn_frame_t exp, input ndn_frame_t act);
    if (act !== exp) begin
        $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
        stop_on_failure();
    end
endtask

task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
        stop_on_failure();
    end
endtask

task automatic compare_face(input string name, input face_t exp, input face_t act);
    if (act !== exp) begin
        $display("[ERROR] %0t %s: expected %0d, actual %0d", $time, name, exp, act);
        stop_on_failure();
    end
endtask

task automatic compare_miss(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[ERROR] %0t %s: expected %b, actual %b", $time, name, exp, act);
        stop_on_failure();
    end
endtask

`endif

// File: testbench/tb_fib_table.sv
`default_nettype none

module tb_fib_table
    import ndn_pkg::*;
();

    localparam int solo_frames    = 20;
    localparam int empty_packets  = 4;
    localparam int rounds         = 4;
    localparam int round_frames   = 10;
    localparam int round_packets  = 16;
    localparam int stimulus_count = solo_frames + 2 * empty_packets
        + rounds * (round_frames + round_packets);

    logic         clk;
    logic         arst_n;
    logic         rx_valid;
    logic [7:0]   rx_data;
    logic         fib_out;
    ndn_header_t  pit_in;
    logic         pit_data_valid;
    logic [7:0]   pit_data;
    logic         cfg_we;
    route_index_t cfg_index;
    route_entry_t cfg_entry;
    ndn_frame_t   pit_out;
    logic         prefix_ready;
    logic         egress_busy;
    logic         tx_valid;
    logic [7:0]   tx_data;
    face_t        tx_face;
    logic         route_miss;

    integer      seed = 32'h6fbb;
    integer      rx_seed;
    ndn_prefix_t round_base;
    ndn_frame_t  exp_frames[$];
    logic [7:0]  exp_tx[$];

    // Monitor bookkeeping, counted in negative clock edges
    int    cyc = 0;
    int    fib_cyc = 0;
    int    last_content_cyc = 0;
    int    last_tx_cyc = 0;
    int    busy_check_cyc = -1;
    int    tx_seen = 0;
    logic  req_pending = 1'b0;
    logic  req_hit = 1'b0;
    logic  req_is_data = 1'b0;
    face_t req_face = '0;

    fib_table UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .fib_out       (fib_out),
        .pit_in        (pit_in),
        .pit_data_valid(pit_data_valid),
        .pit_data      (pit_data),
        .cfg_we        (cfg_we),
        .cfg_index     (cfg_index),
        .cfg_entry     (cfg_entry),
        .pit_out       (pit_out),
        .prefix_ready  (prefix_ready),
        .egress_busy   (egress_busy),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_face       (tx_face),
        .route_miss    (route_miss)
    );

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_problem(input string why);
        $display("%0t %s", $time, why);
        stop_on_failure();
    endtask

`include "tb_fib_model.svh"

    function automatic int bounded_random(inout integer s, input int n);
        logic [31:0] r;
        r = $random(s);
        return int'(r % 32'(n));
    endfunction

    function automatic ndn_prefix_t wide_random(inout integer s);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(s);
        lo = $random(s);
        return {hi, lo};
    endfunction

    // Mostly back to back, with an occasional pause of up to three cycles
    function automatic int gap_length(inout integer s);
        int gap;
        gap = 0;
        if (bounded_random(s, 4) == 0) begin
            gap = 1 + bounded_random(s, 3);
        end
        return gap;
    endfunction

    function automatic ndn_prefix_t near_base_prefix(inout integer s);
        ndn_prefix_t p;
        int          k;
        p = wide_random(s);
        // A fully random prefix is left alone as a likely miss
        if (bounded_random(s, 5) != 0) begin
            for (k = 0; k < 4; k++) begin
                if (bounded_random(s, 4) != 0) begin
                    p[63-16*k -: 16] = round_base[63-16*k -: 16];
                end
            end
        end
        return p;
    endfunction

    task automatic send_rx_byte(input logic [7:0] b, input int gap);
        repeat (gap) begin
            @(posedge clk);
            rx_valid <= 1'b0;
        end
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_data  <= b;
    endtask

    task automatic send_random_frame();
        byte_q_t    b;
        logic [7:0] junk;
        logic       is_data;
        int         n;
        int         i;
        if (bounded_random(rx_seed, 5) == 0) begin
            junk = 8'(bounded_random(rx_seed, 256));
            if ((junk == meta_interest) || (junk == meta_data)) begin
                junk = junk ^ 8'h01;
            end
            send_rx_byte(junk, gap_length(rx_seed));
        end
        is_data = (bounded_random(rx_seed, 2) == 1);
        n = is_data ? data_bytes : interest_bytes;
        b.push_back(is_data ? meta_data : meta_interest);
        for (i = 1; i < n; i++) begin
            b.push_back(8'(bounded_random(rx_seed, 256)));
        end
        exp_frames.push_back(model_frame(b));
        for (i = 0; i < n; i++) begin
            send_rx_byte(b[i], gap_length(rx_seed));
        end
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic run_rx_frames(input int count);
        repeat (count) begin
            send_random_frame();
        end
    endtask

    task automatic write_route(input route_index_t idx, input route_entry_t e);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_index <= idx;
        cfg_entry <= e;
        @(posedge clk);
        cfg_we <= 1'b0;
        model_routes[idx] = e;
    endtask

    task automatic program_table(input logic valid_entries);
        route_entry_t e;
        int           i;
        int           k;
        round_base = wide_random(seed);
        for (i = 0; i < route_entries; i++) begin
            e.valid      = valid_entries && (bounded_random(seed, 8) != 0);
            e.components = 3'(1 + bounded_random(seed, 4));
            e.face       = face_t'(bounded_random(seed, 8));
            e.prefix     = wide_random(seed);
            // Most components follow the base, so entries overlap and compete
            for (k = 0; k < 4; k++) begin
                if (!valid_entries || (bounded_random(seed, 4) != 0)) begin
                    e.prefix[63-16*k -: 16] = round_base[63-16*k -: 16];
                end
            end
            write_route(route_index_t'(i), e);
        end
    endtask

    task automatic wait_egress_idle();
        @(negedge clk);
        while (egress_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic send_packet(input logic is_data, input ndn_prefix_t pfx);
        ndn_header_t   hdr;
        route_result_t exp;
        logic [7:0]    content [content_bytes];
        int            gap;
        int            i;
        hdr.metadata = is_data ? meta_data : meta_interest;
        hdr.prefix   = pfx;
        for (i = 0; i < content_bytes; i++) begin
            content[i] = 8'(bounded_random(seed, 256));
        end
        exp = model_lookup(pfx);
        wait_egress_idle();
        @(posedge clk);
        req_hit     = exp.hit;
        req_face    = exp.face;
        req_is_data = is_data;
        if (exp.hit) begin
            exp_tx.push_back(hdr.metadata);
            for (i = 0; i < 8; i++) begin
                exp_tx.push_back(pfx[63-8*i -: 8]);
            end
            for (i = 0; is_data && (i < content_bytes); i++) begin
                exp_tx.push_back(content[i]);
            end
        end
        fib_out <= 1'b1;
        pit_in  <= hdr;
        @(posedge clk);
        fib_out <= 1'b0;
        // The PIT sends every content byte, hit or miss
        for (i = 0; is_data && (i < content_bytes); i++) begin
            gap = gap_length(seed);
            repeat (gap) begin
                pit_data_valid <= 1'b0;
                @(posedge clk);
            end
            pit_data_valid <= 1'b1;
            pit_data       <= content[i];
            @(posedge clk);
        end
        pit_data_valid <= 1'b0;
    endtask

    task automatic run_packets(input int count);
        logic        is_data;
        ndn_prefix_t pfx;
        repeat (count) begin
            is_data = (bounded_random(seed, 2) == 1);
            pfx     = near_base_prefix(seed);
            send_packet(is_data, pfx);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (arst_n) begin
            if (prefix_ready) begin
                if (exp_frames.size() == 0) begin
                    report_problem("prefix_ready pulsed with no frame in flight");
                end
                compare_frame("pit_out", exp_frames.pop_front(), pit_out);
            end
            if (pit_data_valid) begin
                last_content_cyc = cyc;
            end
            if (fib_out) begin
                fib_cyc     = cyc;
                req_pending = 1'b1;
                tx_seen     = 0;
            end
            // Lookup result lands two cycles after the request, hit or miss
            if (req_pending && (cyc == fib_cyc + 2)) begin
                compare_miss("route_miss", !req_hit, route_miss);
                req_pending = 1'b0;
            end else if (route_miss) begin
                report_problem("route_miss pulsed away from the cycle two after fib_out");
            end
            if (tx_valid) begin
                if (exp_tx.size() == 0) begin
                    report_problem("tx_valid raised while no tx byte was expected");
                end
                if ((tx_seen == 0) && !req_is_data && (cyc != fib_cyc + 2)) begin
                    report_problem("interest transmission did not start two cycles after fib_out");
                end
                if ((tx_seen == 0) && req_is_data && (cyc != last_content_cyc + 2)) begin
                    report_problem("data transmission did not start right after the content");
                end
                if ((tx_seen != 0) && (cyc != last_tx_cyc + 1)) begin
                    report_problem("tx bytes were not sent on consecutive cycles");
                end
                compare_byte("tx_data", exp_tx.pop_front(), tx_data);
                compare_face("tx_face", req_face, tx_face);
                last_tx_cyc = cyc;
                tx_seen     = tx_seen + 1;
                if (tx_seen == (req_is_data ? data_bytes : interest_bytes)) begin
                    busy_check_cyc = cyc + 1;
                end
            end
            if ((cyc == busy_check_cyc) && egress_busy) begin
                report_problem("egress_busy stayed high after the last tx byte");
            end
        end
    end

    initial begin
        #(stimulus_count * 60 * 4);
        report_problem("watchdog expired before the stimulus completed");
    end

    initial begin
        int r;
        rx_seed        = $random(seed);
        arst_n         = 1'b0;
        rx_valid       = 1'b0;
        rx_data        = '0;
        fib_out        = 1'b0;
        pit_in         = '0;
        pit_data_valid = 1'b0;
        pit_data       = '0;
        cfg_we         = 1'b0;
        cfg_index      = '0;
        cfg_entry      = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (prefix_ready || tx_valid || route_miss || egress_busy) begin
            report_problem("outputs were not idle after reset");
        end

        run_rx_frames(solo_frames);

        // Fresh table, then a table written with invalid entries only
        round_base = wide_random(seed);
        run_packets(empty_packets);
        program_table(1'b0);
        run_packets(empty_packets);

        for (r = 0; r < rounds; r++) begin
            program_table(1'b1);
            fork
                run_rx_frames(round_frames);
                run_packets(round_packets);
            join
        end

        wait_egress_idle();
        repeat (8) @(posedge clk);
        if ((exp_frames.size() == 0) && (exp_tx.size() == 0) && !req_pending) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_problem($sformatf("%0d frames and %0d tx bytes never appeared",
                exp_frames.size(), exp_tx.size()));
        end
    end

endmodule

`default_nettype wire

// File: src/fib_table.sv
`default_nettype none

module fib_table
    import ndn_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         rx_valid,
    input  logic [7:0]   rx_data,
    input  logic         fib_out,
    input  ndn_header_t  pit_in,
    input  logic         pit_data_valid,
    input  logic [7:0]   pit_data,
    input  logic         cfg_we,
    input  route_index_t cfg_index,
    input  route_entry_t cfg_entry,
    output ndn_frame_t   pit_out,
    output logic         prefix_ready,
    output logic         egress_busy,
    output logic         tx_valid,
    output logic [7:0]   tx_data,
    output face_t        tx_face,
    output logic         route_miss
);

    route_table_t  routes;
    logic          lookup_req;
    ndn_prefix_t   lookup_prefix;
    route_result_t result;
    logic          lookup_done;

    // Inbound SPI frames toward the PIT
    spi_rx_deframer u_deframer (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .pit_out     (pit_out),
        .prefix_ready(prefix_ready)
    );

    fib_route_regs u_route_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_index(cfg_index),
        .cfg_entry(cfg_entry),
        .routes   (routes)
    );

    fib_route_match u_route_match (
        .clk          (clk),
        .arst_n       (arst_n),
        .routes       (routes),
        .lookup_req   (lookup_req),
        .lookup_prefix(lookup_prefix),
        .result       (result),
        .lookup_done  (lookup_done)
    );

    // Outbound PIT packets toward SPI
    fib_egress u_egress (
        .clk           (clk),
        .arst_n        (arst_n),
        .fib_out       (fib_out),
        .pit_in        (pit_in),
        .pit_data_valid(pit_data_valid),
        .pit_data      (pit_data),
        .result        (result),
        .lookup_done   (lookup_done),
        .lookup_req    (lookup_req),
        .lookup_prefix (lookup_prefix),
        .egress_busy   (egress_busy),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_face       (tx_face),
        .route_miss    (route_miss)
    );

endmodule

`default_nettype wire

// File: src/fib_egress.sv
`default_nettype none

module fib_egress
    import ndn_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          fib_out,
    input  ndn_header_t   pit_in,
    input  logic          pit_data_valid,
    input  logic [7:0]    pit_data,
    input  route_result_t result,
    input  logic          lookup_done,
    output logic          lookup_req,
    output ndn_prefix_t   lookup_prefix,
    output logic          egress_busy,
    output logic          tx_valid,
    output logic [7:0]    tx_data,
    output face_t         tx_face,
    output logic          route_miss
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_collect,
        st_send,
        st_drain
    } state_t;

    state_t       state_q;
    ndn_header_t  hdr_q;
    logic         is_data_q;
    logic [5:0]   content_cnt_q;
    logic [5:0]   tx_cnt_q;
    logic [5:0]   tx_last;
    logic         content_done;
    logic         start_tx;
    ndn_content_t content;
    ndn_frame_t   tx_shift_q;
    face_t        face_q;
    logic         miss_q;

    // Lookup is launched in the request cycle itself
    assign lookup_req    = fib_out;
    assign lookup_prefix = pit_in.prefix;

    assign content_done = (content_cnt_q == 6'(content_bytes));
    assign tx_last      = is_data_q ? 6'(data_bytes - 1) : 6'(interest_bytes - 1);

    assign start_tx = ((state_q == st_lookup) && lookup_done && result.hit && !is_data_q)
        || ((state_q == st_collect) && content_done);

    byte_gather #(
        .word_t(ndn_content_t)
    ) u_content (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (fib_out),
        .byte_valid(pit_data_valid),
        .byte_in   (pit_data),
        .word      (content)
    );

    always_ff @(posedge clk) begin
        if (fib_out) begin
            hdr_q <= pit_in;
        end
    end

    // Interest content stays zero since no bytes follow its header
    always_ff @(posedge clk) begin
        if (start_tx) begin
            tx_shift_q <= '{header: hdr_q, content: content};
        end else if (state_q == st_send) begin
            tx_shift_q <= tx_shift_q << 8;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= st_idle;
            is_data_q     <= 1'b0;
            content_cnt_q <= '0;
            tx_cnt_q      <= '0;
            face_q        <= '0;
            miss_q        <= 1'b0;
        end else begin
            miss_q <= 1'b0;
            if (pit_data_valid) begin
                content_cnt_q <= content_cnt_q + 6'd1;
            end
            case (state_q)
                st_idle: begin
                    if (fib_out) begin
                        state_q       <= st_lookup;
                        is_data_q     <= (pit_in.metadata == meta_data);
                        content_cnt_q <= '0;
                    end
                end
                st_lookup: begin
                    if (lookup_done) begin
                        face_q   <= result.face;
                        tx_cnt_q <= '0;
                        if (!result.hit) begin
                            miss_q  <= 1'b1;
                            state_q <= is_data_q ? st_drain : st_idle;
                        end else begin
                            state_q <= is_data_q ? st_collect : st_send;
                        end
                    end
                end
                st_collect: begin
                    if (start_tx) begin
                        state_q <= st_send;
                    end
                end
                st_send: begin
                    if (tx_cnt_q == tx_last) begin
                        state_q <= st_idle;
                    end else begin
                        tx_cnt_q <= tx_cnt_q + 6'd1;
                    end
                end
                st_drain: begin
                    // Leave on the strobe of the last discarded byte
                    if (pit_data_valid && (content_cnt_q == 6'(content_bytes - 1))) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    assign egress_busy = (state_q != st_idle);
    assign tx_valid    = (state_q == st_send);
    assign tx_data     = tx_shift_q[$bits(ndn_frame_t)-1 -: 8];
    assign tx_face     = face_q;
    assign route_miss  = miss_q;

    // No back-pressure, the PIT has to wait for busy to drop
    assert property (@(posedge clk) disable iff (!arst_n)
        fib_out |-> !egress_busy);

    // Content bytes only belong to a data request still gathering them
    assert property (@(posedge clk) disable iff (!arst_n)
        pit_data_valid |-> (is_data_q && (state_q inside {st_lookup, st_collect, st_drain})));

endmodule

`default_nettype wire

// File: src/fib_route_match.sv
`default_nettype none

module fib_route_match
    import ndn_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  route_table_t  routes,
    input  logic          lookup_req,
    input  ndn_prefix_t   lookup_prefix,
    output route_result_t result,
    output logic          lookup_done
);

    logic [route_entries-1:0] entry_match;
    logic [2:0]               best_len;
    route_result_t            best;
    route_result_t            result_q;
    logic                     done_q;

    // Top components x 16 bits set
    function automatic ndn_prefix_t component_mask(input logic [2:0] components);
        logic [6:0] keep_bits;
        keep_bits = {components, 4'b0000};
        return ~({$bits(ndn_prefix_t){1'b1}} >> keep_bits);
    endfunction

    always_comb begin
        for (int i = 0; i < route_entries; i++) begin
            entry_match[i] = routes[i].valid
                && (routes[i].components inside {[3'd1:3'd4]})
                && (((routes[i].prefix ^ lookup_prefix)
                    & component_mask(routes[i].components)) == '0);
        end
    end

    // Strict compare keeps the lowest index on equal lengths
    always_comb begin
        best     = '0;
        best_len = '0;
        for (int i = 0; i < route_entries; i++) begin
            if (entry_match[i] && (routes[i].components > best_len)) begin
                best_len  = routes[i].components;
                best.hit  = 1'b1;
                best.face = routes[i].face;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= lookup_req;
            if (lookup_req) begin
                result_q <= best;
            end
        end
    end

    assign result      = result_q;
    assign lookup_done = done_q;

endmodule

`default_nettype wire

// File: src/fib_route_regs.sv
`default_nettype none

module fib_route_regs
    import ndn_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         cfg_we,
    input  route_index_t cfg_index,
    input  route_entry_t cfg_entry,
    output route_table_t routes
);

    logic [route_entries-1:0] valid_q;
    route_table_t             entry_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (cfg_we) begin
            valid_q[cfg_index] <= cfg_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            entry_q[cfg_index] <= cfg_entry;
        end
    end

    // Valid bits come from the reset register so a fresh table matches nothing
    always_comb begin
        routes = entry_q;
        for (int i = 0; i < route_entries; i++) begin
            routes[i].valid = valid_q[i];
        end
    end

    // Configuration software must keep component counts within the prefix
    assert property (@(posedge clk) disable iff (!arst_n)
        (cfg_we && cfg_entry.valid) |-> (cfg_entry.components inside {[3'd1:3'd4]}));

endmodule

`default_nettype wire

// File: src/spi_rx_deframer.sv
`default_nettype none

module spi_rx_deframer
    import ndn_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output ndn_frame_t pit_out,
    output logic       prefix_ready
);

    typedef enum logic {
        st_idle,
        st_collect
    } state_t;

    state_t     state_q;
    logic       is_interest_q;
    logic [5:0] count_q;
    logic [5:0] last_index;
    logic       done_q;
    logic       meta_ok;
    logic       gather_valid;
    ndn_frame_t gathered;
    ndn_frame_t framed;
    ndn_frame_t held_q;

    assign meta_ok = (rx_data == meta_interest) || (rx_data == meta_data);

    // Junk first bytes never reach the collector
    assign gather_valid = rx_valid && ((state_q == st_collect) || meta_ok);

    assign last_index = is_interest_q ? 6'(interest_bytes - 1) : 6'(data_bytes - 1);

    byte_gather #(
        .word_t(ndn_frame_t)
    ) u_gather (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (state_q == st_idle),
        .byte_valid(gather_valid),
        .byte_in   (rx_data),
        .word      (gathered)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= st_idle;
            is_interest_q <= 1'b0;
            count_q       <= '0;
            done_q        <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (rx_valid && meta_ok) begin
                        state_q       <= st_collect;
                        is_interest_q <= (rx_data == meta_interest);
                        count_q       <= 6'd1;
                    end
                end
                st_collect: begin
                    if (rx_valid) begin
                        if (count_q == last_index) begin
                            state_q <= st_idle;
                            done_q  <= 1'b1;
                        end else begin
                            count_q <= count_q + 6'd1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // A short interest frame lands in the low 72 bits and moves up to the header
    always_comb begin
        framed = gathered;
        if (is_interest_q) begin
            framed.header  = ndn_header_t'(gathered.content[$bits(ndn_header_t)-1:0]);
            framed.content = '0;
        end
    end

    // Keeps the frame once the collector starts on the next one
    always_ff @(posedge clk) begin
        if (done_q) begin
            held_q <= framed;
        end
    end

    assign pit_out      = done_q ? framed : held_q;
    assign prefix_ready = done_q;

    // Even the shortest frame needs several bytes between completions
    assert property (@(posedge clk) disable iff (!arst_n)
        prefix_ready |=> (!prefix_ready) [*(interest_bytes - 1)]);

endmodule

`default_nettype wire

// File: src/byte_gather.sv
`default_nettype none

module byte_gather #(
    parameter type word_t = logic [7:0]
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clear,
    input  logic       byte_valid,
    input  logic [7:0] byte_in,
    output word_t      word
);

    logic [$bits(word_t)-1:0] shift_q;
    logic [$bits(word_t)+7:0] shifted;

    // New byte enters at the bottom, older bytes move up
    assign shifted = {shift_q, byte_in};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '0;
        end else if (clear) begin
            shift_q <= '0;
            // A byte arriving with clear starts the next word
            if (byte_valid) begin
                shift_q[7:0] <= byte_in;
            end
        end else if (byte_valid) begin
            shift_q <= shifted[$bits(word_t)-1:0];
        end
    end

    assign word = word_t'(shift_q);

endmodule

`default_nettype wire

// File: src/ndn_pkg.sv
`default_nettype none

package ndn_pkg;

    // Metadata byte values that open a frame
    localparam logic [7:0] meta_interest = 8'h70;
    localparam logic [7:0] meta_data     = 8'h30;

    // Frame lengths in bytes, metadata byte included
    localparam int interest_bytes = 9;
    localparam int data_bytes     = 41;
    localparam int content_bytes  = 32;

    localparam int route_entries = 8;

    typedef logic [63:0]  ndn_prefix_t;
    typedef logic [255:0] ndn_content_t;
    typedef logic [2:0]   face_t;
    typedef logic [2:0]   route_index_t;

    typedef struct packed {
        logic [7:0]  metadata;
        ndn_prefix_t prefix;
    } ndn_header_t;

    // Header sits on top, so the frame leaves most significant byte first
    typedef struct packed {
        ndn_header_t  header;
        ndn_content_t content;
    } ndn_frame_t;

    // Components counts 16-bit name pieces from the top of the prefix
    typedef struct packed {
        logic        valid;
        ndn_prefix_t prefix;
        logic [2:0]  components;
        face_t       face;
    } route_entry_t;

    typedef route_entry_t [route_entries-1:0] route_table_t;

    typedef struct packed {
        logic  hit;
        face_t face;
    } route_result_t;

endpackage

`default_nettype wire
